//--- adc_pkg.sv
// shared ADC readout definitions; raw sample is the low 16 bits, APB decode uses addr bits 8:2
package adc_pkg;

   ////////////////////////////////////////
   // vector types
   ////////////////////////////////////////

   // APB byte address and data word
   typedef logic [11:0] apb_addr_t;
   typedef logic [31:0] apb_data_t;

   // raw conversion result, low bits of each sample word
   typedef logic [15:0] adc_raw_t;

   // register word index, addr bits 8:2
   typedef logic [6:0]  reg_idx_t;

   // one bit per interrupt source
   typedef logic [2:0]  int_vec_t;

   ////////////////////////////////////////
   // interrupt bit positions
   ////////////////////////////////////////

   localparam int INT_WMARK = 0;   // fill level above watermark
   localparam int INT_LOW   = 1;   // sample below low threshold
   localparam int INT_HIGH  = 2;   // sample above high threshold

   ////////////////////////////////////////
   // register map, word indices
   ////////////////////////////////////////

   localparam reg_idx_t REG_WATERMARK   = 7'h00;
   localparam reg_idx_t REG_THRESH_LOW  = 7'h01;
   localparam reg_idx_t REG_THRESH_HIGH = 7'h02;
   localparam reg_idx_t REG_INT_EN      = 7'h03;
   localparam reg_idx_t REG_INT_STAT    = 7'h04;   // cleared by read
   localparam reg_idx_t REG_FIFO_STAT   = 7'h05;
   localparam reg_idx_t REG_FIFO_DATA   = 7'h06;   // read pops the FIFO

   // FIFO status codes where overflow wins
   localparam logic [1:0] FIFO_EMPTY = 2'b00;
   localparam logic [1:0] FIFO_DATA  = 2'b01;
   localparam logic [1:0] FIFO_OVFLW = 2'b11;

   ////////////////////////////////////////
   // structs
   ////////////////////////////////////////

   // single-cycle register strobe from the bridge
   typedef struct packed {
      logic      valid;
      logic      write;
      apb_addr_t addr;
      apb_data_t wdata;
   } reg_req_t;

   // threshold level plus compare mode
   typedef struct packed {
      logic     signed_cmp;
      adc_raw_t level;
   } thresh_cfg_t;

endpackage

//--- adc_sample_fifo.sv
// depth is 2**W_ADC_FIFO; push into a full FIFO is dropped unless a pop frees a slot the same edge
`timescale 1ns/100ps

module adc_sample_fifo #(
   parameter int W_ADC_DATA = 32,
   parameter int W_ADC_FIFO = 3
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // write side, straight from the ADC
   input  logic                  push_i,
   input  logic [W_ADC_DATA-1:0] data_i,
   // read side
   input  logic                  pop_i,
   output logic [W_ADC_DATA-1:0] data_o,
   output logic [W_ADC_FIFO:0]   level_o,
   output logic                  ovflw_o
);

   localparam int DEPTH = 2 ** W_ADC_FIFO;

   // one sample word per slot
   logic [W_ADC_DATA-1:0] mem [DEPTH];

   // pointers wrap on their own since depth is a power of two
   logic [W_ADC_FIFO-1:0] wr_ptr_q, rd_ptr_q;
   logic [W_ADC_FIFO:0]   count_q;
   logic                  ovflw_q;

   logic empty, full;
   logic do_push, do_pop;

   assign empty = (count_q == '0);
   assign full  = (count_q == DEPTH[W_ADC_FIFO:0]);

   // pop on empty is ignored
   assign do_pop  = pop_i & ~empty;
   // full plus simultaneous pop still takes the sample
   assign do_push = push_i & (~full | do_pop);

   // head word is zero when nothing is held
   assign data_o  = empty ? '0 : mem[rd_ptr_q];
   assign level_o = count_q;
   assign ovflw_o = ovflw_q;

   ////////////////////////////////////////
   // sample storage
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   ////////////////////////////////////////
   // pointers, fill count, overflow
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
         ovflw_q  <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         // count moves only if exactly one side acts
         case ({do_push, do_pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // a dropped sample sets the flag until reset
         if (push_i && !do_push) begin
            ovflw_q <= 1'b1;
         end
      end
   end

endmodule

//--- adc_ctrl.sv
// needs 16 <= W_ADC_DATA <= 32; interrupt line is combinational and follows the sample strobe
`timescale 1ns/100ps

module adc_ctrl import adc_pkg::*; #(
   parameter int W_ADC_DATA = 32,
   parameter int W_ADC_FIFO = 3
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // register strobe from the bus bridge
   input  reg_req_t              req_i,
   output logic                  block_ready_o,
   output apb_data_t             rdata_o,
   // ADC sample port
   input  logic                  adc_valid_i,
   input  logic [W_ADC_DATA-1:0] adc_data_i,
   output logic                  adc_int_o
);

   // configuration and status registers
   logic [W_ADC_FIFO-1:0] watermark_d, watermark_q;
   thresh_cfg_t           thr_low_d, thr_low_q;
   thresh_cfg_t           thr_high_d, thr_high_q;
   int_vec_t              int_en_d, int_en_q;
   int_vec_t              int_stat_d, int_stat_q;

   // interrupt events and read clear
   int_vec_t int_set, int_clr;
   logic     below_low, above_high;

   reg_idx_t reg_idx;
   adc_raw_t sample_raw;

   // FIFO side
   logic [W_ADC_FIFO:0]   fifo_level;
   logic                  fifo_ovflw;
   logic                  fifo_pop;
   logic [W_ADC_DATA-1:0] fifo_head;
   logic [1:0]            fifo_stat;

   assign reg_idx    = req_i.addr[8:2];
   assign sample_raw = adc_data_i[$bits(adc_raw_t)-1:0];

   // overflow hides the fill state
   always_comb begin
      if (fifo_ovflw) begin
         fifo_stat = FIFO_OVFLW;
      end else if (fifo_level == '0) begin
         fifo_stat = FIFO_EMPTY;
      end else begin
         fifo_stat = FIFO_DATA;
      end
   end

   ////////////////////////////////////////
   // interrupt unit
   ////////////////////////////////////////

   // threshold compares in the mode set per threshold
   always_comb begin
      if (thr_low_q.signed_cmp) begin
         below_low = $signed(sample_raw) < $signed(thr_low_q.level);
      end else begin
         below_low = sample_raw < thr_low_q.level;
      end
      if (thr_high_q.signed_cmp) begin
         above_high = $signed(sample_raw) > $signed(thr_high_q.level);
      end else begin
         above_high = sample_raw > thr_high_q.level;
      end
   end

   // threshold events only during the strobe cycle
   always_comb begin
      int_set            = '0;
      int_set[INT_WMARK] = int_en_q[INT_WMARK] & (fifo_level > {1'b0, watermark_q});
      int_set[INT_LOW]   = int_en_q[INT_LOW] & adc_valid_i & below_low;
      int_set[INT_HIGH]  = int_en_q[INT_HIGH] & adc_valid_i & above_high;
   end

   assign adc_int_o = |int_set;

   // a new event beats the read clear
   assign int_stat_d = int_set | (int_stat_q & ~int_clr);

   ////////////////////////////////////////
   // register access decode
   ////////////////////////////////////////

   always_comb begin
      watermark_d   = watermark_q;
      thr_low_d     = thr_low_q;
      thr_high_d    = thr_high_q;
      int_en_d      = int_en_q;
      rdata_o       = '0;
      int_clr       = '0;
      fifo_pop      = 1'b0;
      // zero-wait so ready rises with the strobe
      block_ready_o = req_i.valid;

      if (req_i.valid && req_i.write) begin
         // only defined bits are stored
         case (reg_idx)
            REG_WATERMARK: watermark_d = req_i.wdata[W_ADC_FIFO-1:0];
            REG_THRESH_LOW: begin
               thr_low_d.level      = req_i.wdata[$bits(adc_raw_t)-1:0];
               thr_low_d.signed_cmp = req_i.wdata[31];
            end
            REG_THRESH_HIGH: begin
               thr_high_d.level      = req_i.wdata[$bits(adc_raw_t)-1:0];
               thr_high_d.signed_cmp = req_i.wdata[31];
            end
            REG_INT_EN: int_en_d = req_i.wdata[$bits(int_vec_t)-1:0];
            default: ;
         endcase
      end else if (req_i.valid) begin
         case (reg_idx)
            REG_WATERMARK: rdata_o[W_ADC_FIFO-1:0] = watermark_q;
            REG_THRESH_LOW: begin
               rdata_o[$bits(adc_raw_t)-1:0] = thr_low_q.level;
               rdata_o[31]                   = thr_low_q.signed_cmp;
            end
            REG_THRESH_HIGH: begin
               rdata_o[$bits(adc_raw_t)-1:0] = thr_high_q.level;
               rdata_o[31]                   = thr_high_q.signed_cmp;
            end
            REG_INT_EN: rdata_o[$bits(int_vec_t)-1:0] = int_en_q;
            REG_INT_STAT: begin
               rdata_o[$bits(int_vec_t)-1:0] = int_stat_q;
               int_clr                       = '1;
            end
            REG_FIFO_STAT: rdata_o[1:0] = fifo_stat;
            REG_FIFO_DATA: begin
               // head word now and pop at the closing edge
               rdata_o[W_ADC_DATA-1:0] = fifo_head;
               fifo_pop                = 1'b1;
            end
            default: ;
         endcase
      end
   end

   ////////////////////////////////////////
   // sample buffer
   ////////////////////////////////////////

   adc_sample_fifo #(
      .W_ADC_DATA (W_ADC_DATA),
      .W_ADC_FIFO (W_ADC_FIFO)
   ) u_fifo (
      .clk     (clk),
      .rst_n   (rst_n),
      .push_i  (adc_valid_i),
      .data_i  (adc_data_i),
      .pop_i   (fifo_pop),
      .data_o  (fifo_head),
      .level_o (fifo_level),
      .ovflw_o (fifo_ovflw)
   );

   // all interrupts off after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         watermark_q <= '0;
         thr_low_q   <= '0;
         thr_high_q  <= '0;
         int_en_q    <= '0;
         int_stat_q  <= '0;
      end else begin
         watermark_q <= watermark_d;
         thr_low_q   <= thr_low_d;
         thr_high_q  <= thr_high_d;
         int_en_q    <= int_en_d;
         int_stat_q  <= int_stat_d;
      end
   end

endmodule

//--- apb_reg_bridge.sv
// APB slave without wait states or pslverr; an access phase with no setup cycle before it is ignored
`timescale 1ns/100ps

module apb_reg_bridge import adc_pkg::*; (
   input  logic      clk,
   input  logic      rst_n,
   // APB slave side
   input  logic      psel_i,
   input  logic      penable_i,
   input  logic      pwrite_i,
   input  apb_addr_t paddr_i,
   input  apb_data_t pwdata_i,
   output apb_data_t prdata_o,
   output logic      pready_o,
   // register block side
   output reg_req_t  req_o,
   input  logic      ready_i,
   input  apb_data_t rdata_i
);

   logic setup_q;
   logic access;

   // setup phase seen in the previous cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         setup_q <= 1'b0;
      end else begin
         setup_q <= psel_i & ~penable_i;
      end
   end

   // legal access phase only
   assign access = psel_i & penable_i & setup_q;

   ////////////////////////////////////////
   // request strobe
   ////////////////////////////////////////

   always_comb begin
      req_o.valid = access;
      req_o.write = pwrite_i;
      req_o.addr  = paddr_i;
      req_o.wdata = pwdata_i;
   end

   // ready comes straight from the block
   assign pready_o = ready_i;

   // read data only on a completing read
   assign prdata_o = (access && !pwrite_i && ready_i) ? rdata_i : '0;

endmodule

//--- adc_subsys_top.sv
// ADC readout top; FIFO depth is 2**W_ADC_FIFO, sample width 16 to 32 bits, APB zero-wait
`timescale 1ns/100ps

module adc_subsys_top import adc_pkg::*; #(
   parameter int W_ADC_DATA = 32,
   parameter int W_ADC_FIFO = 3
) (
   input  logic                  clk,
   input  logic                  rst_n,
   // APB slave
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  apb_addr_t             paddr_i,
   input  apb_data_t             pwdata_i,
   output apb_data_t             prdata_o,
   output logic                  pready_o,
   // ADC front end
   input  logic                  adc_valid_i,
   input  logic [W_ADC_DATA-1:0] adc_data_i,
   // interrupt
   output logic                  adc_int_o
);

   // bridge to controller
   reg_req_t  reg_req;
   logic      block_ready;
   apb_data_t block_rdata;

   apb_reg_bridge u_bridge (
      .clk       (clk),
      .rst_n     (rst_n),
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .req_o     (reg_req),
      .ready_i   (block_ready),
      .rdata_i   (block_rdata)
   );

   adc_ctrl #(
      .W_ADC_DATA (W_ADC_DATA),
      .W_ADC_FIFO (W_ADC_FIFO)
   ) u_ctrl (
      .clk           (clk),
      .rst_n         (rst_n),
      .req_i         (reg_req),
      .block_ready_o (block_ready),
      .rdata_o       (block_rdata),
      .adc_valid_i   (adc_valid_i),
      .adc_data_i    (adc_data_i),
      .adc_int_o     (adc_int_o)
   );

endmodule

//--- tb_adc_subsys.sv
// zero-wait APB master; expected values assume 32-bit samples, FIFO depth 8, stops at first error
`timescale 1ns/100ps

module tb_adc_subsys import adc_pkg::*; ();

   localparam int W_ADC_DATA      = 32;
   localparam int W_ADC_FIFO      = 3;
   localparam int DEPTH           = 1 << W_ADC_FIFO;
   localparam int RESET_CYCLES    = 16;
   // whole sequence runs a few hundred cycles
   localparam int WATCHDOG_CYCLES = 4000;

   logic                  clk;
   logic                  rst_n;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   apb_addr_t             paddr;
   apb_data_t             pwdata;
   apb_data_t             prdata;
   logic                  pready;
   logic                  adc_valid;
   logic [W_ADC_DATA-1:0] adc_data;
   logic                  adc_int;

   // reference model of FIFO contents, overflow, status and register shadows
   logic [W_ADC_DATA-1:0] fifo_q [$];
   logic                  ovflw_model;
   int_vec_t              stat_model;
   apb_data_t             wmark_sh;
   apb_data_t             low_sh;
   apb_data_t             high_sh;
   apb_data_t             en_sh;
   integer                seed;

   adc_subsys_top #(
      .W_ADC_DATA (W_ADC_DATA),
      .W_ADC_FIFO (W_ADC_FIFO)
   ) UUT (
      .clk         (clk),
      .rst_n       (rst_n),
      .psel_i      (psel),
      .penable_i   (penable),
      .pwrite_i    (pwrite),
      .paddr_i     (paddr),
      .pwdata_i    (pwdata),
      .prdata_o    (prdata),
      .pready_o    (pready),
      .adc_valid_i (adc_valid),
      .adc_data_i  (adc_data),
      .adc_int_o   (adc_int)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // error handling
   ////////////////////////////////////////

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_equal(input string name, input apb_data_t exp, input apb_data_t act);
      assert (act === exp) else begin
         $display("** Error at %0d ns: %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   // pready high in every access phase and low elsewhere
   assert property (@(negedge clk) disable iff (!rst_n) pready == (psel && penable))
      else begin
         $display("** Error at %0d ns: pready_o expected %b got %b", $time,
                  psel && penable, pready);
         abort_run();
      end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      abort_run();
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////

   // enabled interrupt events of the current cycle
   function automatic int_vec_t events_now(input logic strobe,
                                           input logic [W_ADC_DATA-1:0] sample);
      adc_raw_t raw;
      adc_raw_t low_lvl;
      adc_raw_t high_lvl;
      int_vec_t ev;
      raw      = sample[15:0];
      low_lvl  = low_sh[15:0];
      high_lvl = high_sh[15:0];
      ev       = '0;
      ev[INT_WMARK] = fifo_q.size() > int'(wmark_sh);
      // bit 31 of each threshold picks signed compare
      ev[INT_LOW]  = strobe && (low_sh[31] ? ($signed(raw) < $signed(low_lvl))
                                           : (raw < low_lvl));
      ev[INT_HIGH] = strobe && (high_sh[31] ? ($signed(raw) > $signed(high_lvl))
                                            : (raw > high_lvl));
      return ev & en_sh[2:0];
   endfunction

   // full FIFO drops the sample
   function automatic void model_push(input logic [W_ADC_DATA-1:0] sample);
      if (fifo_q.size() < DEPTH) begin
         fifo_q.push_back(sample);
      end else begin
         ovflw_model = 1'b1;
      end
   endfunction

   ////////////////////////////////////////
   // APB master and ADC driver
   ////////////////////////////////////////

   // one APB transfer with an optional sample strobe in its access cycle
   task automatic apb_access(input logic wr, input reg_idx_t idx, input apb_data_t wdata,
                             input logic strobe, input logic [W_ADC_DATA-1:0] sample);
      apb_data_t exp_rd;
      int_vec_t  ev;
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= {3'b000, idx, 2'b00};
      pwdata  <= wdata;
      @(posedge clk);
      penable   <= 1'b1;
      adc_valid <= strobe;
      adc_data  <= sample;
      @(negedge clk);
      ev = events_now(strobe, sample);
      // setup cycle saw the same watermark state
      stat_model[INT_WMARK] = stat_model[INT_WMARK] | ev[INT_WMARK];
      exp_rd = '0;
      if (!wr) begin
         case (idx)
            REG_WATERMARK:   exp_rd = wmark_sh;
            REG_THRESH_LOW:  exp_rd = low_sh;
            REG_THRESH_HIGH: exp_rd = high_sh;
            REG_INT_EN:      exp_rd = en_sh;
            REG_INT_STAT:    exp_rd = apb_data_t'(stat_model);
            REG_FIFO_STAT: begin
               if (ovflw_model) begin
                  exp_rd = 32'h3;
               end else if (fifo_q.size() != 0) begin
                  exp_rd = 32'h1;
               end
            end
            REG_FIFO_DATA: begin
               // empty pop reads zero
               if (fifo_q.size() != 0) begin
                  exp_rd = fifo_q.pop_front();
               end
            end
            default: ;
         endcase
      end
      check_equal("pready_o", 32'h1, apb_data_t'(pready));
      check_equal("prdata_o", exp_rd, prdata);
      check_equal("adc_int_o", apb_data_t'(|ev), apb_data_t'(adc_int));
      // read clears the status but a new event still sets it
      if (!wr && idx == REG_INT_STAT) begin
         stat_model = ev;
      end else begin
         stat_model = stat_model | ev;
      end
      if (wr) begin
         case (idx)
            REG_WATERMARK:   wmark_sh = wdata & apb_data_t'(DEPTH - 1);
            REG_THRESH_LOW:  low_sh   = wdata & 32'h8000_FFFF;
            REG_THRESH_HIGH: high_sh  = wdata & 32'h8000_FFFF;
            REG_INT_EN:      en_sh    = wdata & 32'h0000_0007;
            default: ;
         endcase
      end
      if (strobe) begin
         model_push(sample);
      end
      @(posedge clk);
      psel      <= 1'b0;
      penable   <= 1'b0;
      adc_valid <= 1'b0;
   endtask

   task automatic apb_write(input reg_idx_t idx, input apb_data_t data);
      apb_access(1'b1, idx, data, 1'b0, '0);
   endtask

   task automatic apb_read(input reg_idx_t idx);
      apb_access(1'b0, idx, '0, 1'b0, '0);
   endtask

   // one-cycle sample strobe with the interrupt checked in that cycle
   task automatic adc_push(input logic [W_ADC_DATA-1:0] sample);
      int_vec_t ev;
      @(posedge clk);
      adc_valid <= 1'b1;
      adc_data  <= sample;
      @(negedge clk);
      ev = events_now(1'b1, sample);
      check_equal("adc_int_o", apb_data_t'(|ev), apb_data_t'(adc_int));
      stat_model = stat_model | ev;
      model_push(sample);
      @(posedge clk);
      adc_valid <= 1'b0;
   endtask

   task automatic drain_fifo();
      while (fifo_q.size() != 0) begin
         apb_read(REG_FIFO_DATA);
      end
   endtask

   // fixed probes with and without the sign bit plus two random ones
   task automatic threshold_round(input apb_data_t low_cfg, input apb_data_t high_cfg);
      logic [W_ADC_DATA-1:0] probe [6];
      probe[0] = 32'h0000_0050;
      probe[1] = 32'h0000_8000;
      probe[2] = 32'h0000_1234;
      probe[3] = 32'h0000_FFF0;
      probe[4] = $random(seed);
      probe[5] = $random(seed);
      apb_write(REG_THRESH_LOW, low_cfg);
      apb_write(REG_THRESH_HIGH, high_cfg);
      foreach (probe[i]) begin
         adc_push(probe[i]);
         apb_read(REG_INT_STAT);
         apb_read(REG_INT_STAT);
      end
      drain_fifo();
   endtask

   ////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////

   initial begin
      seed        = 32'h1578f99c;
      rst_n       = 1'b0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      adc_valid   = 1'b0;
      adc_data    = '0;
      ovflw_model = 1'b0;
      stat_model  = '0;
      wmark_sh    = '0;
      low_sh      = '0;
      high_sh     = '0;
      en_sh       = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // idle outputs after reset and masked register readback
      @(negedge clk);
      check_equal("pready_o", 32'h0, apb_data_t'(pready));
      check_equal("adc_int_o", 32'h0, apb_data_t'(adc_int));
      apb_read(REG_INT_EN);
      apb_read(REG_INT_STAT);
      apb_read(REG_FIFO_STAT);
      apb_write(REG_WATERMARK, 32'hFFFF_FFFA);
      apb_read(REG_WATERMARK);
      apb_write(REG_THRESH_LOW, 32'hFFFF_1234);
      apb_read(REG_THRESH_LOW);
      apb_write(REG_THRESH_HIGH, 32'h7FFF_ABCD);
      apb_read(REG_THRESH_HIGH);
      apb_write(REG_INT_EN, 32'hFFFF_FFF5);
      apb_read(REG_INT_EN);
      apb_write(REG_INT_EN, 32'h0);

      // samples come back in push order
      repeat (5) adc_push($random(seed));
      apb_read(REG_FIFO_STAT);
      drain_fifo();
      apb_read(REG_FIFO_DATA);
      apb_read(REG_FIFO_STAT);

      // threshold interrupts in unsigned then signed mode
      apb_write(REG_INT_EN, 32'h6);
      threshold_round(32'h0000_0100, 32'h0000_7000);
      threshold_round(32'h8000_FF00, 32'h8000_0100);

      // status read in the cycle of a new low event
      adc_push(32'h0000_8000);
      apb_access(1'b0, REG_INT_STAT, '0, 1'b1, 32'h0000_8000);
      apb_read(REG_INT_STAT);
      apb_read(REG_INT_STAT);
      drain_fifo();

      // watermark of 2 raises the interrupt while more than two are held
      apb_write(REG_INT_EN, 32'h1);
      apb_write(REG_WATERMARK, 32'h2);
      repeat (4) adc_push($random(seed));
      drain_fifo();
      apb_read(REG_INT_STAT);
      apb_write(REG_INT_EN, 32'h0);

      // overflow flag stays set after draining, dropped samples never read back
      repeat (DEPTH + 2) adc_push($random(seed));
      apb_read(REG_FIFO_STAT);
      drain_fifo();
      apb_read(REG_FIFO_DATA);
      apb_read(REG_FIFO_STAT);

      $display("TB PASSED");
      $finish;
   end

endmodule

//--- vlog.f
adc_pkg.sv
adc_sample_fifo.sv
adc_ctrl.sv
apb_reg_bridge.sv
adc_subsys_top.sv
tb_adc_subsys.sv

//--- Makefile
# Verilator build and run of the ADC readout testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_subsys
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
